// File: verilog/styler_macros.svh
/*
 * Width macros for the glyph styler
 * Control word reset value
 * Scanline numbers of the underline, strikethrough and overline
 */
`ifndef STYLER_MACROS_SVH
`define STYLER_MACROS_SVH

`define STYLER_SCAN_W 4      // Display or font scanline number
`define STYLER_ROW_W  16     // One row of glyph pixels
`define STYLER_ATTR_W 25     // Attribute word
`define STYLER_CTRL_W 6      // Display control word

// Blink, lines, cursor and cursor blink on, cursor covers no rows
`define STYLER_CTRL_RESET 6'h3C

`define STYLER_UNDER_ROW  4'd14  // Double form also uses 13 and 15
`define STYLER_STRIKE_ROW 4'd7   // Double form also uses 6 and 8
`define STYLER_OVER_ROW   4'd0   // Double form also uses 2

`endif

// File: verilog/glyph_pkg.sv
/*
 * Glyph data types: scanline number, pixel row, attribute word
 */
`include "styler_macros.svh"

package glyph_pkg;

  typedef logic [`STYLER_SCAN_W-1:0] scanline_t;  // 0 is the top scanline

  typedef logic [`STYLER_ROW_W-1:0] pixelRow_t;   // Bit 15 is the leftmost pixel

  // Attribute bits from 0 upward
  //   0..3    xoffset, xscale, yoffset, yscale
  //   4..7    xPreMirror, xPostMirror, yPreMirror, yPostMirror
  //   8..11   bold, faint, italic, reverseItalic
  //   12..15  blink, alternate, inverse, hidden
  //   16..18  underline, doubleUnderline, dottedUnderline
  //   19..21  strikethru, doubleStrikethru, dottedStrikethru
  //   22..24  overline, doubleOverline, dottedOverline
  typedef logic [`STYLER_ATTR_W-1:0] attr_t;

endpackage

// File: verilog/stylerRegs_pkg.sv
/*
 * Register select encoding for pad access
 * Display control word type
 */
`include "styler_macros.svh"

package stylerRegs_pkg;

  typedef enum logic [2:0] {
    SEL_SCAN   = 3'd0,  // Display scanline
    SEL_CTRL   = 3'd1,
    SEL_ROW_LO = 3'd2,  // Font row, low byte
    SEL_ROW_HI = 3'd3,
    SEL_ATTR0  = 3'd4,  // Attribute bits 7..0
    SEL_ATTR1  = 3'd5,
    SEL_ATTR2  = 3'd6,
    SEL_ATTR3  = 3'd7   // Attribute bit 24 only
  } regSel_e;

  // Bits from 5 down:
  //   blinkEnable, lineEnable, cursorEnable,
  //   cursorBlink, cursorTop, cursorBottom
  typedef logic [`STYLER_CTRL_W-1:0] ctrl_t;

endpackage

// File: verilog/styleRegs.sv
/*
 * Styler register block
 * Scanline, control, font row and attribute registers
 * Byte lane write decode from the pad bus
 */
`include "styler_macros.svh"

module styleRegs
  import glyph_pkg::*;
  import stylerRegs_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  regSel_e    sel,
  input  logic       writeN,
  input  logic [7:0] wrData,
  output scanline_t  scanIn,
  output ctrl_t      ctrl,
  output pixelRow_t  rowIn,
  output attr_t      attr
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      scanIn <= '0;
      ctrl   <= `STYLER_CTRL_RESET;
      rowIn  <= '0;
      attr   <= '0;
    end else if (!writeN) begin  // Level write, repeats each cycle
      case (sel)
        SEL_SCAN: begin
          scanIn <= wrData[`STYLER_SCAN_W-1:0];
        end
        SEL_CTRL: begin
          ctrl <= wrData[`STYLER_CTRL_W-1:0];
        end
        SEL_ROW_LO: begin
          rowIn[7:0] <= wrData;
        end
        SEL_ROW_HI: begin
          rowIn[15:8] <= wrData;
        end
        SEL_ATTR0: begin
          attr[7:0] <= wrData;
        end
        SEL_ATTR1: begin
          attr[15:8] <= wrData;
        end
        SEL_ATTR2: begin
          attr[23:16] <= wrData;
        end
        SEL_ATTR3: begin
          attr[`STYLER_ATTR_W-1] <= wrData[0];  // Dotted overline
        end
      endcase
    end
  end

endmodule

// File: verilog/glyphGeometry.sv
/*
 * Glyph geometry
 * Display to font scanline remap with mirror, double height, offset
 * Horizontal mirror and double width of the fetched font row
 */
module glyphGeometry
  import glyph_pkg::*;
(
  input  scanline_t scanIn,
  input  pixelRow_t rowIn,
  input  attr_t     attr,
  output scanline_t scanOut,
  output pixelRow_t geomRow
);

  logic xoffset, xscale, yoffset, yscale;
  logic xPreMirror, xPostMirror, yPreMirror, yPostMirror;
  scanline_t preScan, scaledScan;
  pixelRow_t preRow, scaledRow;
  logic [7:0] srcByte;

  assign {yPostMirror, yPreMirror, xPostMirror, xPreMirror,
          yscale, yoffset, xscale, xoffset} = attr[7:0];

  function automatic pixelRow_t reverseRow(input pixelRow_t r);
    pixelRow_t res;
    for (int i = 0; i < $bits(pixelRow_t); i++) begin
      res[i] = r[$bits(pixelRow_t)-1-i];
    end
    return res;
  endfunction

  function automatic pixelRow_t doubleByte(input logic [7:0] b);
    pixelRow_t res;
    for (int i = 0; i < 8; i++) begin
      res[2*i]   = b[i];
      res[2*i+1] = b[i];
    end
    return res;
  endfunction

  // Vertical path, 15 - n is the bitwise complement
  assign preScan    = yPreMirror ? ~scanIn : scanIn;
  assign scaledScan = yscale ? {yoffset, preScan[3:1]} : preScan;  // Half, plus 8 for lower half
  assign scanOut    = yPostMirror ? ~scaledScan : scaledScan;

  // Horizontal path
  assign preRow    = xPreMirror ? reverseRow(rowIn) : rowIn;
  assign srcByte   = xoffset ? preRow[15:8] : preRow[7:0];
  assign scaledRow = xscale ? doubleByte(srcByte) : preRow;
  assign geomRow   = xPostMirror ? reverseRow(scaledRow) : scaledRow;

endmodule

// File: verilog/glyphDecorate.sv
/*
 * Glyph decoration on one pixel row
 * Italic, bold, faint, blink and hidden
 * Under, strike and over lines, inverse and block cursor
 */
`include "styler_macros.svh"

module glyphDecorate
  import glyph_pkg::*;
  import stylerRegs_pkg::*;
(
  input  scanline_t scanIn,
  input  pixelRow_t geomRow,
  input  attr_t     attr,
  input  ctrl_t     ctrl,
  input  logic      faintPhase,
  input  logic      blinkPhase,
  input  logic      cursorPhase,
  output pixelRow_t rowOut
);

  localparam pixelRow_t solidLine  = 16'hFFFF;
  localparam pixelRow_t dottedLine = 16'h5555;  // Also the faint mask in its high phase
  localparam pixelRow_t faintOdd   = 16'hAAAA;

  logic bold, faint, italic, reverseItalic;
  logic blink, alternate, inverse, hidden;
  logic underline, doubleUnderline, dottedUnderline;
  logic strikethru, doubleStrikethru, dottedStrikethru;
  logic overline, doubleOverline, dottedOverline;
  logic blinkEnable, lineEnable, cursorEnable, cursorBlink, cursorTop, cursorBottom;

  logic topHalf, blinkOff, cursorOn, cursorRow;
  pixelRow_t slantRow, boldRow, faintRow, visRow, lineMask, lineRow, invRow;

  assign {dottedOverline, doubleOverline, overline,
          dottedStrikethru, doubleStrikethru, strikethru,
          dottedUnderline, doubleUnderline, underline,
          hidden, inverse, alternate, blink,
          reverseItalic, italic, faint, bold} = attr[24:8];

  assign {blinkEnable, lineEnable, cursorEnable,
          cursorBlink, cursorTop, cursorBottom} = ctrl;

  assign topHalf = ~scanIn[3];  // Scanlines 0 to 7

  // Slant the upper half only
  always_comb begin
    slantRow = geomRow;
    if (italic && topHalf) slantRow = slantRow >> 1;
    if (reverseItalic && topHalf) slantRow = slantRow << 1;
  end

  assign boldRow  = bold ? (slantRow | (slantRow >> 1)) : slantRow;
  assign faintRow = faint ? (boldRow & (faintPhase ? dottedLine : faintOdd)) : boldRow;

  // Alternate blinks in the opposite phase
  assign blinkOff = blink && blinkEnable && !(blinkPhase ^ alternate);
  assign visRow   = (hidden || blinkOff) ? '0 : faintRow;

  always_comb begin
    lineMask = '0;
    if (lineEnable) begin
      if (underline && scanIn == `STYLER_UNDER_ROW) lineMask |= solidLine;
      if (doubleUnderline && (scanIn == `STYLER_UNDER_ROW - 4'd1 ||
                              scanIn == `STYLER_UNDER_ROW + 4'd1)) lineMask |= solidLine;
      if (dottedUnderline && scanIn == `STYLER_UNDER_ROW) lineMask |= dottedLine;

      if (strikethru && scanIn == `STYLER_STRIKE_ROW) lineMask |= solidLine;
      if (doubleStrikethru && (scanIn == `STYLER_STRIKE_ROW - 4'd1 ||
                               scanIn == `STYLER_STRIKE_ROW + 4'd1)) lineMask |= solidLine;
      if (dottedStrikethru && scanIn == `STYLER_STRIKE_ROW) lineMask |= dottedLine;

      if (overline && scanIn == `STYLER_OVER_ROW) lineMask |= solidLine;
      if (doubleOverline && (scanIn == `STYLER_OVER_ROW ||
                             scanIn == `STYLER_OVER_ROW + 4'd2)) lineMask |= solidLine;
      if (dottedOverline && scanIn == `STYLER_OVER_ROW) lineMask |= dottedLine;
    end
  end

  assign lineRow = visRow | lineMask;
  assign invRow  = inverse ? ~lineRow : lineRow;  // Lines invert with the glyph

  // Steady cursor, or blinking with cursorPhase
  assign cursorOn  = cursorEnable && (!cursorBlink || cursorPhase);
  assign cursorRow = topHalf ? cursorTop : cursorBottom;
  assign rowOut    = (cursorOn && cursorRow) ? ~invRow : invRow;

endmodule

// File: verilog/stylerTop.sv
/*
 * Glyph styler top level
 * Register block, geometry and decoration path
 * Pad readback multiplexer and pad output enable
 */
module stylerTop
  import glyph_pkg::*;
  import stylerRegs_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic [2:0] sel,
  input  logic       writeN,
  input  logic [7:0] wrData,
  input  logic       faintPhase,
  input  logic       blinkPhase,
  input  logic       cursorPhase,
  input  logic       busDisable,
  output logic [7:0] rdData,
  output logic [7:0] busOut,
  output logic [7:0] busOe
);

  regSel_e    selE;
  scanline_t  scanIn, scanOut;
  ctrl_t      ctrl;
  pixelRow_t  rowIn, geomRow, rowOut;
  attr_t      attr;
  logic [7:0] rdByte;

  assign selE = regSel_e'(sel);

  styleRegs i_styleRegs (
    .clk    (clk),
    .rst_n  (rst_n),
    .sel    (selE),
    .writeN (writeN),
    .wrData (wrData),
    .scanIn (scanIn),
    .ctrl   (ctrl),
    .rowIn  (rowIn),
    .attr   (attr)
  );

  glyphGeometry i_glyphGeometry (
    .scanIn  (scanIn),
    .rowIn   (rowIn),
    .attr    (attr),
    .scanOut (scanOut),
    .geomRow (geomRow)
  );

  glyphDecorate i_glyphDecorate (
    .scanIn      (scanIn),
    .geomRow     (geomRow),
    .attr        (attr),
    .ctrl        (ctrl),
    .faintPhase  (faintPhase),
    .blinkPhase  (blinkPhase),
    .cursorPhase (cursorPhase),
    .rowOut      (rowOut)
  );

  // Results read back on the row and scanline selects, attributes as stored
  always_comb begin
    case (selE)
      SEL_SCAN:   rdByte = 8'(scanOut);  // Fetched font scanline
      SEL_CTRL:   rdByte = 8'(ctrl);
      SEL_ROW_LO: rdByte = rowOut[7:0];
      SEL_ROW_HI: rdByte = rowOut[15:8];
      SEL_ATTR0:  rdByte = attr[7:0];
      SEL_ATTR1:  rdByte = attr[15:8];
      SEL_ATTR2:  rdByte = attr[23:16];
      SEL_ATTR3:  rdByte = 8'(attr[24]);
      default:    rdByte = '0;
    endcase
  end

  assign rdData = rdByte;
  assign busOut = rdByte;
  assign busOe  = {8{~busDisable}};  // Drive the pads unless disabled

endmodule

// File: dv/styler_assert.sv
/*
 * Concurrent assertions on the styler registers and pad enable
 * Bound into the top level, where the register outputs are visible
 */
`include "styler_macros.svh"

module styler_assert
  import glyph_pkg::*;
  import stylerRegs_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic       writeN,
  input scanline_t  scanIn,
  input ctrl_t      ctrl,
  input pixelRow_t  rowIn,
  input attr_t      attr,
  input logic       busDisable,
  input logic [7:0] busOe
);

  // Control word leaves reset with blink, lines and cursor enabled
  ctrlAfterReset: assert property (@(posedge clk) !rst_n |=> ctrl == `STYLER_CTRL_RESET)
    else $error("control word wrong on the cycle after reset");

  regsHold: assert property (@(posedge clk) disable iff (!rst_n)
    writeN |=> $stable({scanIn, ctrl, rowIn, attr}))
    else $error("register changed without a write strobe");

  padEnable: assert property (@(posedge clk) !busDisable |-> busOe == 8'hFF)
    else $error("pad enable not all ones while the bus is enabled");

endmodule

bind stylerTop styler_assert i_stylerAssert (
  .clk        (clk),
  .rst_n      (rst_n),
  .writeN     (writeN),
  .scanIn     (scanIn),
  .ctrl       (ctrl),
  .rowIn      (rowIn),
  .attr       (attr),
  .busDisable (busDisable),
  .busOe      (busOe)
);

// File: dv/stylerTb.sv
/*
 * Testbench for the glyph styler
 * Replays write and check records from the stimulus file
 * Compares pad readback and pad enable with the expected values
 */
module stylerTb;

  localparam string STIM_FILE    = "dv/styler_stimulus.txt";
  localparam int    MAX_RECORDS  = 1000;  // Bound on the replay loop
  localparam int    READY_CYCLES = 10;

  logic       clk;
  logic       rst_n;
  logic [2:0] sel;
  logic       writeN;
  logic [7:0] wrData;
  logic       faintPhase;
  logic       blinkPhase;
  logic       cursorPhase;
  logic       busDisable;
  logic [7:0] rdData;
  logic [7:0] busOut;
  logic [7:0] busOe;

  int   checkCount = 0;
  int   failCount  = 0;
  int   errorCount = 0;
  logic ready;

  stylerTop i_stylerTop (
    .clk         (clk),
    .rst_n       (rst_n),
    .sel         (sel),
    .writeN      (writeN),
    .wrData      (wrData),
    .faintPhase  (faintPhase),
    .blinkPhase  (blinkPhase),
    .cursorPhase (cursorPhase),
    .busDisable  (busDisable),
    .rdData      (rdData),
    .busOut      (busOut),
    .busOe       (busOe)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Register takes the byte on the edge after the strobe goes low
  task automatic writeReg(input logic [2:0] s, input logic [7:0] d);
    @(posedge clk);
    #2;
    sel    = s;
    wrData = d;
    writeN = 1'b0;
    @(posedge clk);
    #2;
    writeN = 1'b1;
  endtask

  task automatic checkRead(
    input logic [8*16-1:0] name,
    input logic [2:0]      s,
    input logic            fp, bp, cp, bd,
    input logic [7:0]      expRd, expOe
  );
    logic ok;
    ok = 1'b1;
    @(posedge clk);
    #2;
    sel         = s;
    faintPhase  = fp;
    blinkPhase  = bp;
    cursorPhase = cp;
    busDisable  = bd;
    @(negedge clk);  // Mid-cycle, combinational path settled
    checkCount++;
    if (rdData !== expRd) begin
      $display("CHECK FAILED %0s rdData expected %02h actual %02h", name, expRd, rdData);
      ok = 1'b0;
    end
    if (busOut !== expRd) begin
      $display("CHECK FAILED %0s busOut expected %02h actual %02h", name, expRd, busOut);
      ok = 1'b0;
    end
    if (busOe !== expOe) begin
      $display("CHECK FAILED %0s busOe expected %02h actual %02h", name, expOe, busOe);
      ok = 1'b0;
    end
    if (ok) begin
      $display("passed %0s", name);
    end else begin
      failCount++;
    end
  endtask

  // Control readback shows its reset value once the block is out of reset
  task automatic waitReady(output logic isReady);
    int cycles;
    isReady = 1'b0;
    cycles  = 0;
    while (!isReady && cycles < READY_CYCLES) begin
      @(posedge clk);
      #2;
      sel = 3'd1;
      @(negedge clk);
      if (rdData == 8'h3C) begin
        isReady = 1'b1;
      end
      cycles++;
    end
  endtask

  task automatic replayStimulus();
    int               fd;
    int               count;
    int               records;
    logic             done;
    logic [7:0]       kind;
    logic [8*16-1:0]  name;
    logic [8*128-1:0] restOfLine;
    logic [2:0]       s;
    logic [7:0]       d, expRd, expOe;
    logic             fp, bp, cp, bd;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("could not open the stimulus file %0s", STIM_FILE);
      errorCount++;
    end else begin
      done    = 1'b0;
      records = 0;
      while (!done && records < MAX_RECORDS) begin
        count = $fscanf(fd, "%s", kind);
        if (count != 1) begin
          done = 1'b1;  // End of file
        end else if (kind == "#") begin
          count = $fgets(restOfLine, fd);
        end else if (kind == "w") begin
          count = $fscanf(fd, "%h %h", s, d);
          if (count == 2) begin
            writeReg(s, d);
          end else begin
            $display("write record %0d in the stimulus file is malformed", records);
            errorCount++;
            done = 1'b1;
          end
        end else if (kind == "c") begin
          count = $fscanf(fd, "%s %h %h %h %h %h %h %h",
                          name, s, fp, bp, cp, bd, expRd, expOe);
          if (count == 8) begin
            checkRead(name, s, fp, bp, cp, bd, expRd, expOe);
          end else begin
            $display("check record %0d in the stimulus file is malformed", records);
            errorCount++;
            done = 1'b1;
          end
        end else begin
          $display("record %0d in the stimulus file has an unknown type", records);
          errorCount++;
          done = 1'b1;
        end
        records++;
      end
      if (!done) begin
        $display("stimulus file has more than %0d records", MAX_RECORDS);
        errorCount++;
      end
      $fclose(fd);
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    sel         = 3'd0;
    writeN      = 1'b1;
    wrData      = 8'h00;
    faintPhase  = 1'b0;
    blinkPhase  = 1'b0;
    cursorPhase = 1'b0;
    busDisable  = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    waitReady(ready);
    if (ready) begin
      replayStimulus();
    end else begin
      $display("timed out waiting for the control register to leave reset");
      errorCount++;
    end
    if (checkCount == 0) begin
      $display("no checks were run");
      errorCount++;
    end
    $display("%0d checks, %0d failed, %0d other errors", checkCount, failCount, errorCount);
    if (failCount == 0 && errorCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: dv/styler_stimulus.txt
# w <sel> <data>  writes one register byte
# c <name> <sel> <faint> <blink> <cursor> <busDisable> <rdData> <busOe>, numbers in hex
c rstCtrl 1 1 1 0 0 3c ff
c rstAttr0 4 1 1 0 0 00 ff
c rstAttr3 7 1 1 0 0 00 ff
w 1 2a
c ctrlWr 1 1 1 0 0 2a ff
w 6 81
c attr2Wr 6 1 1 0 0 81 ff
w 7 ff
c attr3Bit 7 1 1 0 0 01 ff
c busOff 1 1 1 0 1 2a 00
w 6 00
w 7 00
w 1 00
# vertical geometry on scanlines 3 and 10
w 0 03
c vPlain 0 1 1 0 0 03 ff
w 4 40
c vPreMir 0 1 1 0 0 0c ff
w 4 0c
c vHalfOff 0 1 1 0 0 09 ff
w 4 cc
c vAll 0 1 1 0 0 01 ff
w 0 0a
w 4 0c
c vLowHalf 0 1 1 0 0 0d ff
# horizontal geometry, font row 12c4
w 2 c4
w 3 12
c hPlainHi 3 1 1 0 0 12 ff
w 4 02
c hDblHi 3 1 1 0 0 f0 ff
w 4 03
c hDblOffLo 2 1 1 0 0 0c ff
w 4 22
c hDblPostLo 2 1 1 0 0 0f ff
w 4 12
c hPreDblHi 3 1 1 0 0 30 ff
# shape decorations, font row 0ff0
w 4 00
w 2 f0
w 3 0f
w 0 03
w 5 04
c italicLo 2 1 1 0 0 f8 ff
w 0 09
c italicLower 3 1 1 0 0 0f ff
w 0 03
w 5 08
c revItalicHi 3 1 1 0 0 1f ff
w 5 05
c boldItalic 2 1 1 0 0 fc ff
w 5 02
c faintHigh 2 1 1 0 0 50 ff
c faintLow 2 0 1 0 0 a0 ff
w 5 03
c boldFaint 2 0 1 0 0 a8 ff
w 5 80
c hidden 2 1 1 0 0 00 ff
w 5 10
w 1 20
c blinkOff 2 1 0 0 0 00 ff
c blinkOn 2 1 1 0 0 f0 ff
w 5 30
c altBlinkLow 2 1 0 0 0 f0 ff
c altBlinkHigh 2 1 1 0 0 00 ff
# lines, inverse and cursor
w 5 00
w 1 10
w 6 01
w 0 0e
c under14 2 1 1 0 0 ff ff
w 1 00
c underNoEn 2 1 1 0 0 f0 ff
w 1 10
w 6 04
c dotUnder 3 1 1 0 0 5f ff
w 6 10
w 0 06
c dblStrike6 2 1 1 0 0 ff ff
w 6 00
w 7 01
w 0 00
c dotOver 3 1 1 0 0 5f ff
w 7 00
w 6 01
w 5 40
w 0 0e
c invUnder 2 1 1 0 0 00 ff
w 6 00
w 5 00
w 1 0a
w 0 03
c curTop 3 1 1 0 0 f0 ff
w 0 09
c curTopMiss 3 1 1 0 0 0f ff
w 1 0d
c curBlinkOff 3 1 1 0 0 0f ff
c curBlinkOn 3 1 1 1 0 f0 ff

// File: tb.f
+incdir+verilog
verilog/glyph_pkg.sv
verilog/stylerRegs_pkg.sv
verilog/styleRegs.sv
verilog/glyphGeometry.sv
verilog/glyphDecorate.sv
verilog/stylerTop.sv
dv/styler_assert.sv
dv/stylerTb.sv

// File: Makefile
# Verilator build and run of the glyph styler testbench

VERILATOR ?= verilator
TOP       ?= stylerTb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(OBJ_DIR)
